/* design/switch_cfg.svh */
`ifndef SWITCH_CFG_SVH
`define SWITCH_CFG_SVH

// port and lane sizes
`define SW_PORTS        4
`define SW_PORT_W       2
`define SW_DATA_W       8
`define SW_LEN_W        7

// accepted frame lengths in bytes
`define SW_MIN_FRAME    14
`define SW_MAX_FRAME    64

`define SW_QUEUE_DEPTH  256   // bytes per queue
`define SW_QUEUE_AW     8
`define SW_PTR_DEPTH    16    // frames per queue

`define SW_TABLE_AW     4     // 16 table entries
`define SW_IFG          12    // idle cycles after each tx frame

`endif

/* design/switch_pkg.sv */
`default_nettype none
`include "switch_cfg.svh"

package switch_pkg;

	typedef logic [`SW_DATA_W-1:0]   byte_t;
	typedef logic [`SW_PORT_W-1:0]   port_t;
	typedef logic [`SW_PORTS-1:0]    portmap_t;
	typedef logic [`SW_LEN_W-1:0]    len_t;
	typedef logic [47:0]             mac_t;
	typedef logic [`SW_TABLE_AW-1:0] tbl_idx_t;

	// byte lane framed by a data-valid level
	typedef struct packed {
		logic  dv;
		byte_t data;
	} stream_t;

	typedef struct packed {
		mac_t  da;
		mac_t  sa;
		port_t src_port;
	} lookup_req_t;

	typedef struct packed {
		portmap_t portmap;
		logic     filtered;   // dest sits on the source port
	} lookup_rsp_t;

	typedef enum logic [2:0] {
		FP_IDLE,
		FP_HEADER,
		FP_LOOKUP,
		FP_WAIT_ROOM,
		FP_COPY,
		FP_RELEASE
	} fp_state_t;

endpackage

`default_nettype wire

/* design/port_queue.sv */
`timescale 1ns/1ps
`default_nettype none
`include "switch_cfg.svh"

module port_queue #(
	parameter int LEN_FIFO_DEPTH = `SW_PTR_DEPTH
) (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire switch_pkg::stream_t wr,
	input  wire logic                pop_byte,
	input  wire logic                pop_frame,
	output logic                     frame_ready,
	output logic                     room,
	output switch_pkg::len_t         head_len,
	output switch_pkg::byte_t        rd_byte
);
	localparam int LAW = (LEN_FIFO_DEPTH > 1) ? $clog2(LEN_FIFO_DEPTH) : 1;
	localparam int LCW = $clog2(LEN_FIFO_DEPTH + 1);

	switch_pkg::byte_t     mem [`SW_QUEUE_DEPTH];
	switch_pkg::len_t      len_mem [LEN_FIFO_DEPTH];
	logic [`SW_QUEUE_AW:0] wr_ptr;   // runs ahead of cm_ptr inside a frame
	logic [`SW_QUEUE_AW:0] cm_ptr;
	logic [`SW_QUEUE_AW:0] rd_ptr;
	logic [`SW_QUEUE_AW:0] used;
	logic [LAW-1:0]        lw_ptr;
	logic [LAW-1:0]        lr_ptr;
	logic [LCW-1:0]        len_cnt;
	switch_pkg::len_t      wr_cnt;
	logic                  in_frame;
	logic                  keep;     // frame was accepted at its first byte
	logic                  ovf;
	logic                  byte_wr;
	logic                  commit;

	assign used = wr_ptr - rd_ptr;
	assign room = (len_cnt != LCW'(LEN_FIFO_DEPTH)) &&
		(used <= (`SW_QUEUE_DEPTH - `SW_MAX_FRAME));
	// bytes past the max length are not stored and the frame is dropped at its end
	assign byte_wr = wr.dv && (in_frame ? (keep && wr_cnt != `SW_MAX_FRAME) : room);
	assign commit = !wr.dv && in_frame && keep && !ovf && wr_cnt >= `SW_MIN_FRAME;

	always_ff @(posedge clk) begin
		if (byte_wr)
			mem[wr_ptr[`SW_QUEUE_AW-1:0]] <= wr.data;
		if (commit)
			len_mem[lw_ptr] <= wr_cnt;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			cm_ptr   <= '0;
			rd_ptr   <= '0;
			lw_ptr   <= '0;
			lr_ptr   <= '0;
			len_cnt  <= '0;
			wr_cnt   <= '0;
			in_frame <= 1'b0;
			keep     <= 1'b0;
			ovf      <= 1'b0;
		end else begin
			if (wr.dv) begin
				if (!in_frame) begin
					in_frame <= 1'b1;
					keep     <= room;
					ovf      <= 1'b0;
					wr_cnt   <= switch_pkg::len_t'(1);
				end else if (keep) begin
					if (wr_cnt == `SW_MAX_FRAME)
						ovf <= 1'b1;
					else
						wr_cnt <= wr_cnt + 1'b1;
				end
			end else if (in_frame) begin
				in_frame <= 1'b0;
				if (commit)
					cm_ptr <= wr_ptr;
				else
					wr_ptr <= cm_ptr;   // rewind to drop the frame
			end
			if (byte_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_byte)
				rd_ptr <= rd_ptr + 1'b1;
			if (commit)
				lw_ptr <= (lw_ptr == LAW'(LEN_FIFO_DEPTH - 1)) ? '0 : lw_ptr + 1'b1;
			if (pop_frame)
				lr_ptr <= (lr_ptr == LAW'(LEN_FIFO_DEPTH - 1)) ? '0 : lr_ptr + 1'b1;
			case ({commit, pop_frame})
				2'b10: len_cnt <= len_cnt + 1'b1;
				2'b01: len_cnt <= len_cnt - 1'b1;
				default: len_cnt <= len_cnt;
			endcase
		end
	end

	assign frame_ready = (len_cnt != '0);
	assign head_len = len_mem[lr_ptr];
	assign rd_byte = mem[rd_ptr[`SW_QUEUE_AW-1:0]];

	a_pop_needs_frame: assert property (@(posedge clk) disable iff (!rst_n)
		(pop_byte || pop_frame) |-> frame_ready);

	a_len_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		frame_ready |-> (head_len <= `SW_MAX_FRAME));

endmodule

`default_nettype wire

/* design/interface_mux.sv */
`timescale 1ns/1ps
`default_nettype none
`include "switch_cfg.svh"

module interface_mux (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire switch_pkg::portmap_t q_ready,
	input  wire switch_pkg::len_t     q_len [`SW_PORTS],
	input  wire switch_pkg::byte_t    q_byte [`SW_PORTS],
	input  wire logic                 pop_byte,
	input  wire logic                 pop_frame,
	output switch_pkg::portmap_t      q_pop_byte,
	output switch_pkg::portmap_t      q_pop_frame,
	output logic                      frame_ready,
	output switch_pkg::len_t          head_len,
	output switch_pkg::byte_t         rd_byte,
	output switch_pkg::port_t         src_port
);
	switch_pkg::port_t sel;
	switch_pkg::port_t last;   // port served most recently
	switch_pkg::port_t nxt;
	switch_pkg::port_t cand;
	logic              locked;
	logic              found;

	// first ready port after the last one served
	always_comb begin
		nxt = last;
		cand = last;
		found = 1'b0;
		for (int i = 1; i <= `SW_PORTS; i++) begin
			cand = switch_pkg::port_t'((int'(last) + i) % `SW_PORTS);
			if (!found && q_ready[cand]) begin
				nxt = cand;
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			locked <= 1'b0;
			sel    <= '0;
			last   <= switch_pkg::port_t'(`SW_PORTS - 1);
		end else if (!locked) begin
			if (found) begin
				locked <= 1'b1;
				sel    <= nxt;
			end
		end else if (pop_frame) begin
			locked <= 1'b0;
			last   <= sel;
		end
	end

	assign frame_ready = locked && q_ready[sel];
	assign head_len = q_len[sel];
	assign rd_byte = q_byte[sel];
	assign src_port = sel;
	assign q_pop_byte = switch_pkg::portmap_t'(locked && pop_byte) << sel;
	assign q_pop_frame = switch_pkg::portmap_t'(locked && pop_frame) << sel;

	a_sel_held: assert property (@(posedge clk) disable iff (!rst_n)
		(locked && !pop_frame) |=> $stable(sel));

endmodule

`default_nettype wire

/* design/mac_table.sv */
`timescale 1ns/1ps
`default_nettype none
`include "switch_cfg.svh"

module mac_table (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire logic                    lookup_req,
	input  wire switch_pkg::lookup_req_t req,
	output logic                         lookup_ack,
	output switch_pkg::lookup_rsp_t      rsp
);
	localparam int ENTRIES = 1 << `SW_TABLE_AW;

	logic [ENTRIES-1:0]      valid;
	switch_pkg::mac_t        ent_mac [ENTRIES];
	switch_pkg::port_t       ent_port [ENTRIES];
	switch_pkg::tbl_idx_t    sa_idx;
	switch_pkg::tbl_idx_t    da_idx;
	logic                    hit_valid;
	switch_pkg::mac_t        hit_mac;
	switch_pkg::port_t       hit_port;
	switch_pkg::lookup_rsp_t rsp_d;

	assign sa_idx = req.sa[`SW_TABLE_AW-1:0];
	assign da_idx = req.da[`SW_TABLE_AW-1:0];

	always_comb begin
		// learning comes first, so the entry written now wins
		if (da_idx == sa_idx) begin
			hit_valid = 1'b1;
			hit_mac = req.sa;
			hit_port = req.src_port;
		end else begin
			hit_valid = valid[da_idx];
			hit_mac = ent_mac[da_idx];
			hit_port = ent_port[da_idx];
		end
		rsp_d.filtered = 1'b0;
		rsp_d.portmap = ~(switch_pkg::portmap_t'(1) << req.src_port);  // flood
		if (req.da != '1 && hit_valid && hit_mac == req.da) begin
			if (hit_port == req.src_port) begin
				rsp_d.filtered = 1'b1;
				rsp_d.portmap = '0;
			end else begin
				rsp_d.portmap = switch_pkg::portmap_t'(1) << hit_port;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid      <= '0;
			lookup_ack <= 1'b0;
		end else begin
			lookup_ack <= lookup_req;
			if (lookup_req)
				valid[sa_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (lookup_req) begin
			ent_mac[sa_idx]  <= req.sa;
			ent_port[sa_idx] <= req.src_port;
			rsp              <= rsp_d;
		end
	end

	a_ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		lookup_req |=> (lookup_ack && !lookup_req));

endmodule

`default_nettype wire

/* design/frame_process.sv */
`timescale 1ns/1ps
`default_nettype none
`include "switch_cfg.svh"

module frame_process (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire logic                    frame_ready,
	input  wire switch_pkg::len_t        head_len,
	input  wire switch_pkg::byte_t       rd_byte,
	input  wire switch_pkg::port_t       src_port,
	input  wire logic                    lookup_ack,
	input  wire switch_pkg::lookup_rsp_t rsp,
	input  wire switch_pkg::portmap_t    tx_room,
	output logic                         pop_byte,
	output logic                         pop_frame,
	output logic                         lookup_req,
	output switch_pkg::lookup_req_t      req,
	output switch_pkg::stream_t          tx_wr [`SW_PORTS]
);
	localparam int HDR_LEN = 12;   // da + sa

	switch_pkg::fp_state_t state;
	switch_pkg::byte_t     hdr [HDR_LEN];
	switch_pkg::len_t      cnt;
	switch_pkg::portmap_t  map;     // empty when filtered
	switch_pkg::byte_t     out_byte;
	logic                  copy_hdr;

	// byte 0 is the top byte of the address
	always_comb begin
		for (int i = 0; i < 6; i++) begin
			req.da[47 - 8*i -: 8] = hdr[i];
			req.sa[47 - 8*i -: 8] = hdr[6 + i];
		end
		req.src_port = src_port;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= switch_pkg::FP_IDLE;
			cnt        <= '0;
			map        <= '0;
			lookup_req <= 1'b0;
		end else begin
			lookup_req <= 1'b0;
			case (state)
				switch_pkg::FP_IDLE: begin
					if (frame_ready) begin
						state <= switch_pkg::FP_HEADER;
						cnt   <= '0;
					end
				end
				switch_pkg::FP_HEADER: begin
					cnt <= cnt + 1'b1;
					if (cnt == switch_pkg::len_t'(HDR_LEN - 1)) begin
						state      <= switch_pkg::FP_LOOKUP;
						lookup_req <= 1'b1;
					end
				end
				switch_pkg::FP_LOOKUP: begin
					if (lookup_ack) begin
						map   <= rsp.filtered ? '0 : rsp.portmap;
						state <= switch_pkg::FP_WAIT_ROOM;
					end
				end
				switch_pkg::FP_WAIT_ROOM: begin
					// every destination needs room for a max frame
					if ((tx_room & map) == map) begin
						state <= switch_pkg::FP_COPY;
						cnt   <= '0;
					end
				end
				switch_pkg::FP_COPY: begin
					cnt <= cnt + 1'b1;
					if (cnt == head_len - 1'b1)
						state <= switch_pkg::FP_RELEASE;
				end
				switch_pkg::FP_RELEASE: begin
					state <= switch_pkg::FP_IDLE;
				end
				default: state <= switch_pkg::FP_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == switch_pkg::FP_HEADER)
			hdr[cnt[3:0]] <= rd_byte;
	end

	assign copy_hdr = (cnt < HDR_LEN);
	assign out_byte = copy_hdr ? hdr[cnt[3:0]] : rd_byte;   // replay header first
	assign pop_byte = (state == switch_pkg::FP_HEADER) ||
		(state == switch_pkg::FP_COPY && !copy_hdr);
	assign pop_frame = (state == switch_pkg::FP_RELEASE);

	always_comb begin
		for (int p = 0; p < `SW_PORTS; p++) begin
			tx_wr[p].dv = (state == switch_pkg::FP_COPY) && map[p];
			tx_wr[p].data = out_byte;
		end
	end

	// table result must never point back at the ingress port
	a_no_hairpin: assert property (@(posedge clk) disable iff (!rst_n)
		(state == switch_pkg::FP_COPY) |-> !map[src_port]);

endmodule

`default_nettype wire

/* design/tx_port.sv */
`timescale 1ns/1ps
`default_nettype none
`include "switch_cfg.svh"

module tx_port (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic              frame_ready,
	input  wire switch_pkg::len_t  head_len,
	input  wire switch_pkg::byte_t rd_byte,
	output logic                   pop_byte,
	output logic                   pop_frame,
	output switch_pkg::stream_t    tx
);
	localparam int GW = $clog2(`SW_IFG + 1);

	logic             busy;
	switch_pkg::len_t cnt;
	logic [GW-1:0]    gap;   // idle cycles still owed
	logic             last_byte;

	assign last_byte = busy && (cnt == head_len - 1'b1);
	assign pop_byte = busy;
	assign pop_frame = last_byte;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy  <= 1'b0;
			cnt   <= '0;
			gap   <= '0;
			tx.dv <= 1'b0;
		end else begin
			tx.dv   <= busy;
			tx.data <= rd_byte;
			if (busy) begin
				cnt <= cnt + 1'b1;
				if (last_byte) begin
					busy <= 1'b0;
					gap  <= GW'(`SW_IFG - 1);   // output lags by one cycle
				end
			end else if (gap != '0) begin
				gap <= gap - 1'b1;
			end else if (frame_ready) begin
				busy <= 1'b1;
				cnt  <= '0;
			end
		end
	end

endmodule

`default_nettype wire

/* design/l2_switch_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "switch_cfg.svh"

module l2_switch_top (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire switch_pkg::stream_t rx [`SW_PORTS],
	output switch_pkg::stream_t      tx [`SW_PORTS]
);
	switch_pkg::portmap_t    rx_ready;
	switch_pkg::len_t        rx_len [`SW_PORTS];
	switch_pkg::byte_t       rx_byte [`SW_PORTS];
	switch_pkg::portmap_t    rx_pop_byte;
	switch_pkg::portmap_t    rx_pop_frame;
	logic                    sel_ready;
	switch_pkg::len_t        sel_len;
	switch_pkg::byte_t       sel_byte;
	switch_pkg::port_t       sel_port;
	logic                    fp_pop_byte;
	logic                    fp_pop_frame;
	logic                    lookup_req;
	logic                    lookup_ack;
	switch_pkg::lookup_req_t req;
	switch_pkg::lookup_rsp_t rsp;
	switch_pkg::stream_t     tx_wr [`SW_PORTS];
	switch_pkg::portmap_t    tx_room;
	switch_pkg::portmap_t    tx_ready;
	switch_pkg::len_t        tx_len [`SW_PORTS];
	switch_pkg::byte_t       tx_byte [`SW_PORTS];
	switch_pkg::portmap_t    tx_pop_byte;
	switch_pkg::portmap_t    tx_pop_frame;

	interface_mux u_interface_mux (
		.clk(clk), .rst_n(rst_n),
		.q_ready(rx_ready), .q_len(rx_len), .q_byte(rx_byte),
		.pop_byte(fp_pop_byte), .pop_frame(fp_pop_frame),
		.q_pop_byte(rx_pop_byte), .q_pop_frame(rx_pop_frame),
		.frame_ready(sel_ready), .head_len(sel_len),
		.rd_byte(sel_byte), .src_port(sel_port)
	);

	frame_process u_frame_process (
		.clk(clk), .rst_n(rst_n),
		.frame_ready(sel_ready), .head_len(sel_len), .rd_byte(sel_byte), .src_port(sel_port),
		.lookup_ack(lookup_ack), .rsp(rsp), .tx_room(tx_room),
		.pop_byte(fp_pop_byte), .pop_frame(fp_pop_frame),
		.lookup_req(lookup_req), .req(req), .tx_wr(tx_wr)
	);

	mac_table u_mac_table (
		.clk(clk), .rst_n(rst_n),
		.lookup_req(lookup_req), .req(req),
		.lookup_ack(lookup_ack), .rsp(rsp)
	);

	for (genvar p = 0; p < `SW_PORTS; p++) begin : g_port
		port_queue #(.LEN_FIFO_DEPTH(`SW_PTR_DEPTH)) u_rx_queue (
			.clk(clk), .rst_n(rst_n), .wr(rx[p]),
			.pop_byte(rx_pop_byte[p]), .pop_frame(rx_pop_frame[p]),
			.frame_ready(rx_ready[p]), .room(),   // rx side drops whole frames itself
			.head_len(rx_len[p]), .rd_byte(rx_byte[p])
		);

		port_queue #(.LEN_FIFO_DEPTH(`SW_PTR_DEPTH)) u_tx_queue (
			.clk(clk), .rst_n(rst_n), .wr(tx_wr[p]),
			.pop_byte(tx_pop_byte[p]), .pop_frame(tx_pop_frame[p]),
			.frame_ready(tx_ready[p]), .room(tx_room[p]),
			.head_len(tx_len[p]), .rd_byte(tx_byte[p])
		);

		tx_port u_tx_port (
			.clk(clk), .rst_n(rst_n),
			.frame_ready(tx_ready[p]), .head_len(tx_len[p]), .rd_byte(tx_byte[p]),
			.pop_byte(tx_pop_byte[p]), .pop_frame(tx_pop_frame[p]),
			.tx(tx[p])
		);
	end

endmodule

`default_nettype wire

/* dv/tb_l2_switch.sv */
`timescale 1ns/1ps
`default_nettype none
`include "switch_cfg.svh"

module tb_l2_switch;
	localparam int TIMEOUT_CYCLES = 20000;   // about ten times the whole run
	localparam int MAX_FRAMES = 64;
	localparam int TBL_SIZE = 1 << `SW_TABLE_AW;

	logic                clk;
	logic                rst_n;
	switch_pkg::stream_t rx [`SW_PORTS];
	switch_pkg::stream_t tx [`SW_PORTS];

	logic              tbl_valid [TBL_SIZE];   // reference table
	switch_pkg::mac_t  tbl_mac [TBL_SIZE];
	switch_pkg::port_t tbl_port [TBL_SIZE];
	switch_pkg::byte_t fmem [MAX_FRAMES][`SW_MAX_FRAME];
	int                flen [MAX_FRAMES];
	int                fsrc [MAX_FRAMES];
	string             fname [MAX_FRAMES];
	int                nframes;
	int                expq [`SW_PORTS][$];   // frame ids per output
	switch_pkg::byte_t rbuf [`SW_PORTS][`SW_MAX_FRAME];
	int                rcnt [`SW_PORTS];
	int                val_errs;
	int                frm_errs;
	int unsigned       cycles;

	l2_switch_top i_dut (.clk(clk), .rst_n(rst_n), .rx(rx), .tx(tx));

	always #4 clk = ~clk;

	// byte 10 carries the input port and byte 11 the table index
	function automatic switch_pkg::mac_t station(input int port, input int idx);
		return {8'h02, 24'h0, 8'(port), 8'(idx)};
	endfunction

	function automatic switch_pkg::portmap_t route_model(input switch_pkg::mac_t da,
			input switch_pkg::mac_t sa, input int src);
		int                   si;
		int                   di;
		switch_pkg::portmap_t map;
		si = int'(sa[`SW_TABLE_AW-1:0]);
		di = int'(da[`SW_TABLE_AW-1:0]);
		tbl_valid[si] = 1'b1;   // learn before lookup
		tbl_mac[si] = sa;
		tbl_port[si] = switch_pkg::port_t'(src);
		map = ~(switch_pkg::portmap_t'(1) << src);
		if (da != '1 && tbl_valid[di] && tbl_mac[di] == da) begin
			if (int'(tbl_port[di]) == src)
				map = '0;
			else
				map = switch_pkg::portmap_t'(1) << tbl_port[di];
		end
		return map;
	endfunction

	function automatic int pending();
		int n;
		n = 0;
		for (int p = 0; p < `SW_PORTS; p++)
			n += expq[p].size();
		return n;
	endfunction

	task automatic send_frame(input int port, input switch_pkg::mac_t da,
			input switch_pkg::mac_t sa, input int len, input string name, input int gap);
		switch_pkg::byte_t    fb [80];
		switch_pkg::portmap_t map;
		int                   id;
		for (int i = 0; i < len; i++) begin
			if (i < 6)
				fb[i] = da[47 - 8*i -: 8];
			else if (i < 12)
				fb[i] = sa[95 - 8*i -: 8];
			else
				fb[i] = switch_pkg::byte_t'($urandom);
		end
		if (len >= `SW_MIN_FRAME && len <= `SW_MAX_FRAME) begin   // runts and giants leave no trace
			id = nframes;
			nframes++;
			for (int i = 0; i < len; i++)
				fmem[id][i] = fb[i];
			flen[id] = len;
			fsrc[id] = int'(sa[15:8]);   // byte 10 of the frame
			fname[id] = name;
			map = route_model(da, sa, port);
			for (int o = 0; o < `SW_PORTS; o++)
				if (map[o])
					expq[o].push_back(id);
		end
		for (int i = 0; i < len; i++) begin
			@(negedge clk);
			rx[port].dv = 1'b1;
			rx[port].data = fb[i];
		end
		@(negedge clk);
		rx[port] = '0;
		repeat (gap) @(negedge clk);
	endtask

	task automatic burst(input int port, input switch_pkg::mac_t da);
		for (int n = 0; n < 2; n++)
			send_frame(port, da, station(port, 8 + port),
				`SW_MIN_FRAME + int'($urandom % 51), "concurrency", 0);
	endtask

	// oldest expected frame with the same byte 10
	task automatic check_frame(input int p);
		int k;
		int id;
		int src;
		k = -1;
		src = (rcnt[p] > 10) ? int'(rbuf[p][10]) : -1;
		for (int j = 0; j < expq[p].size(); j++)
			if (k < 0 && fsrc[expq[p][j]] == src)
				k = j;
		assert (k >= 0) else begin
			frm_errs++;
			$display("port %0d sent a frame of %0d bytes from input %0d that was not expected",
				p, rcnt[p], src);
		end
		if (k >= 0) begin
			id = expq[p][k];
			expq[p].delete(k);
			assert (rcnt[p] == flen[id]) else begin
				val_errs++;
				$display("** Error %s: port %0d length expected %0d, actual %0d",
					fname[id], p, flen[id], rcnt[p]);
			end
			for (int i = 0; i < rcnt[p] && i < flen[id]; i++)
				assert (rbuf[p][i] == fmem[id][i]) else begin
					val_errs++;
					$display("** Error %s: port %0d byte %0d expected %02h, actual %02h",
						fname[id], p, i, fmem[id][i], rbuf[p][i]);
				end
		end
	endtask

	for (genvar p = 0; p < `SW_PORTS; p++) begin : g_mon
		int idle = 1000;
		always @(negedge clk) begin
			if (rst_n && tx[p].dv) begin
				if (rcnt[p] == 0)
					assert (idle >= `SW_IFG) else begin
						frm_errs++;
						$display("port %0d left only %0d idle cycles between frames", p, idle);
					end
				if (rcnt[p] < `SW_MAX_FRAME)
					rbuf[p][rcnt[p]] = tx[p].data;
				rcnt[p]++;
			end else if (rcnt[p] != 0) begin
				check_frame(p);
				rcnt[p] = 0;
				idle = 1;
			end else if (idle < 1000) begin
				idle++;
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, %0d expected frames never arrived",
				cycles, pending());
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'hbb30));
		clk = 1'b0;
		rst_n = 1'b0;
		nframes = 0;
		val_errs = 0;
		frm_errs = 0;
		cycles = 0;
		for (int p = 0; p < `SW_PORTS; p++) begin
			rx[p] = '0;
			rcnt[p] = 0;
		end
		for (int i = 0; i < TBL_SIZE; i++)
			tbl_valid[i] = 1'b0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		send_frame(0, station(3, 5), station(0, 1), 20, "flood", 30);
		send_frame(2, station(0, 1), station(2, 2), 24, "learn", 30);
		send_frame(1, station(2, 2), station(1, 3), 40, "learn", 30);
		send_frame(2, station(2, 2), station(2, 4), 30, "filter", 30);   // dest on own port
		send_frame(3, station(1, 3), '1, 16, "broadcast", 30);   // learns the all-ones address
		send_frame(3, '1, station(3, 6), 50, "broadcast", 30);   // index 15 matches on port 3

		fork
			burst(0, station(2, 2));
			burst(1, station(0, 1));
			burst(2, station(1, 3));
			burst(3, station(0, 1));
		join
		repeat (30) @(negedge clk);

		send_frame(1, station(2, 2), station(1, 7), 10, "drop", 30);
		send_frame(1, station(2, 2), station(1, 7), 70, "drop", 30);
		send_frame(1, station(2, 2), station(1, 12), `SW_MIN_FRAME, "drop", 30);

		while (pending() != 0)
			@(posedge clk);
		repeat (200) @(posedge clk);   // room for stray frames to show up
		$display("errors: %0d value, %0d frame", val_errs, frm_errs);
		if (val_errs == 0 && frm_errs == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+design
design/switch_pkg.sv
design/port_queue.sv
design/interface_mux.sv
design/mac_table.sv
design/frame_process.sv
design/tx_port.sv
design/l2_switch_top.sv
dv/tb_l2_switch.sv
